//--- filelist.f
+incdir+.
pce_io_pkg.sv
cart_loader.sv
joypad_mux.sv
backup_ram.sv
pce_io_top.sv
tb_pce_io.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator
# the run counts as failed when the log holds the fail message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -f filelist.f --top-module tb_pce_io -o tb_pce_io \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_pce_io > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- tb_pce_io_checks.svh
`ifndef TB_PCE_IO_CHECKS_SVH
`define TB_PCE_IO_CHECKS_SVH

// first wrong value ends the run
task automatic report_mismatch(input string msg);
  $display("[ERROR] %0t ns: %s", $time, msg);
  $display("Result: FAILED");
  $fatal(1, "wrong value from the DUT");
endtask

// download address
task automatic check_rom_addr(input pce_io_pkg::rom_addr_t got,
                              input pce_io_pkg::rom_addr_t exp, input string what);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  end
endtask

// data word toward the rom memory
task automatic check_rom_word(input pce_io_pkg::rom_word_t got,
                              input pce_io_pkg::rom_word_t exp, input string what);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  end
endtask

// single flags and toggles
task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
  end
endtask

// joypad port nibble
task automatic check_nibble(input pce_io_pkg::pad_nibble_t got,
                            input pce_io_pkg::pad_nibble_t exp, input string what);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  end
endtask

// backup ram, core side
task automatic check_byte(input pce_io_pkg::bram_byte_t got,
                          input pce_io_pkg::bram_byte_t exp, input string what);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  end
endtask

// backup ram, save buffer side
task automatic check_save_word(input pce_io_pkg::save_word_t got,
                               input pce_io_pkg::save_word_t exp, input string what);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  end
endtask

`endif

//--- tb_pce_io.sv
`timescale 1ns/100ps

module tb_pce_io;

  localparam int clk_period = 8;
  localparam int n_short_dl = 6;
  localparam int short_words = 24;
  localparam int n_sig_dl = 4;
  // long downloads end between 0x2130 and 0x222e, past both signature areas
  localparam int min_sig_words = 'h1098;
  localparam int max_sig_words = 'h1118;
  localparam int n_joy = 400;
  localparam int n_bram_ops = 600;
  // worst case is a rom word, two cycles high and two low
  localparam int cycles_per_txn = 4;
  localparam int n_txn = n_short_dl * short_words + n_sig_dl * max_sig_words + n_joy +
                         pce_io_pkg::bram_words + n_bram_ops * 3 + 100;

  logic clk_sys_42_95;
  logic reset;
  logic cart_download;
  logic ioctl_wr;
  pce_io_pkg::rom_word_t ioctl_dout;
  logic byte_swap;
  pce_io_pkg::core_rom_addr_t core_rd_addr;
  pce_io_pkg::rom_addr_t rom_wr_addr;
  pce_io_pkg::rom_word_t rom_wr_data;
  logic rom_wr_req;
  logic rom_populous;
  pce_io_pkg::rom_addr_t sdram_rd_addr;
  logic [1:0] joy_out;
  logic multitap_enable;
  pce_io_pkg::pad_buttons_t pad_p1;
  pce_io_pkg::pad_buttons_t pad_p2;
  pce_io_pkg::pad_buttons_t pad_p3;
  pce_io_pkg::pad_buttons_t pad_p4;
  pce_io_pkg::pad_nibble_t joy_in;
  pce_io_pkg::bram_addr_t bram_addr;
  pce_io_pkg::bram_byte_t bram_data;
  logic bram_wr;
  pce_io_pkg::bram_byte_t bram_q;
  pce_io_pkg::save_lba_t sd_lba;
  pce_io_pkg::save_offset_t sd_buff_addr;
  pce_io_pkg::save_word_t sd_buff_dout;
  logic sd_wr;
  pce_io_pkg::save_word_t sd_buff_din;

  integer seed;
  // model of the loader
  pce_io_pkg::rom_addr_t m_addr;
  logic m_req;
  logic [1:0] m_pop;
  // model of the multitap scan
  pce_io_pkg::tap_port_t m_port;
  pce_io_pkg::pad_nibble_t m_latch;
  logic m_last_sel;
  // backup ram contents as words
  pce_io_pkg::save_word_t m_mem [pce_io_pkg::bram_words];

  `include "tb_pce_io_checks.svh"

  pce_io_top dut (.*);

  always #(clk_period / 2) clk_sys_42_95 = ~clk_sys_42_95;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [7:0] rev8(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[7-i] = b[i];
    end
    return r;
  endfunction

  // bytes exchanged, each one bit reversed
  function automatic pce_io_pkg::rom_word_t swap_word(input pce_io_pkg::rom_word_t w);
    return {rev8(w[7:0]), rev8(w[15:8])};
  endfunction

  // expected word per slot, zero off the four slots
  function automatic pce_io_pkg::rom_word_t sig_word_at(input logic [3:0] off);
    case (off)
      4'd6: return pce_io_pkg::sig_word_6;
      4'd8: return pce_io_pkg::sig_word_8;
      4'd10: return pce_io_pkg::sig_word_10;
      4'd12: return pce_io_pkg::sig_word_12;
      default: return '0;
    endcase
  endfunction

  function automatic logic breaks_signature(input pce_io_pkg::rom_addr_t a,
                                            input pce_io_pkg::rom_word_t w);
    logic in_area;
    logic slot;
    in_area = (a[23:4] == pce_io_pkg::populous_block_a) ||
              (a[23:4] == pce_io_pkg::populous_block_b);
    slot = (a[3:0] == 4'd6) || (a[3:0] == 4'd8) || (a[3:0] == 4'd10) || (a[3:0] == 4'd12);
    return in_area && slot && (w != sig_word_at(a[3:0]));
  endfunction

  // active-low nibble for one port and half
  function automatic pce_io_pkg::pad_nibble_t pad_nibble(input pce_io_pkg::tap_port_t port,
                                                         input logic sel,
                                                         input pce_io_pkg::pad_buttons_t p);
    if (port >= 3'd4) begin
      return 4'hf;
    end
    if (sel) begin
      return ~{p.up, p.right, p.left, p.down};
    end
    return ~{p.start, p.select, p.b, p.a};
  endfunction

  task automatic start_download();
    cart_download = 1'b0;
    @(negedge clk_sys_42_95);
    cart_download = 1'b1;
    repeat (2) @(negedge clk_sys_42_95);
    m_addr = '0;
    m_pop = 2'b11;
    check_rom_addr(rom_wr_addr, m_addr, "rom_wr_addr after download start");
    check_bit(rom_populous, 1'b1, "rom_populous after download start");
  endtask

  // one strobe, two cycles high then two low
  task automatic write_rom_word(input pce_io_pkg::rom_word_t w, input logic swap);
    pce_io_pkg::rom_word_t exp_data;
    exp_data = swap ? swap_word(w) : w;
    ioctl_dout = w;
    byte_swap = swap;
    ioctl_wr = 1'b1;
    repeat (2) @(negedge clk_sys_42_95);
    m_req = ~m_req;
    if (breaks_signature(m_addr, exp_data)) begin
      m_pop[m_addr[13]] = 1'b0;
    end
    check_rom_word(rom_wr_data, exp_data, "rom_wr_data");
    check_bit(rom_wr_req, m_req, "rom_wr_req after strobe");
    check_rom_addr(rom_wr_addr, m_addr, "rom_wr_addr while strobe high");
    ioctl_wr = 1'b0;
    repeat (2) @(negedge clk_sys_42_95);
    m_addr = m_addr + 24'd2;
    check_rom_addr(rom_wr_addr, m_addr, "rom_wr_addr after strobe");
  endtask

  // good area gets the real signature, the other random words
  task automatic sig_download(input logic good_a, input logic good_b, input int n_words);
    logic [31:0] r;
    pce_io_pkg::rom_word_t w;
    start_download();
    for (int i = 0; i < n_words; i++) begin
      r = rand32();
      w = r[15:0];
      if (((m_addr[23:4] == pce_io_pkg::populous_block_a) && good_a) ||
          ((m_addr[23:4] == pce_io_pkg::populous_block_b) && good_b)) begin
        if (sig_word_at(m_addr[3:0]) != '0) begin
          // full reversal undoes itself
          w = r[16] ? swap_word(sig_word_at(m_addr[3:0])) : sig_word_at(m_addr[3:0]);
        end
      end
      write_rom_word(w, r[16]);
    end
  endtask

  task automatic check_header_reads(input int count);
    logic [31:0] r;
    pce_io_pkg::core_rom_addr_t sum;
    check_bit(rom_populous, m_pop[m_addr[9]], "rom_populous at end of download");
    for (int i = 0; i < count; i++) begin
      r = rand32();
      core_rd_addr = r[21:0];
      @(negedge clk_sys_42_95);
      sum = core_rd_addr;
      if (m_addr[9]) begin
        sum = sum + pce_io_pkg::core_rom_addr_t'(pce_io_pkg::header_offset);
      end
      check_rom_addr(sdram_rd_addr, {2'b00, sum}, "sdram_rd_addr");
    end
  endtask

  // one clock of the multitap as the core sees it
  task automatic model_joy_cycle();
    pce_io_pkg::pad_buttons_t p;
    case (m_port[1:0])
      2'd0: p = pad_p1;
      2'd1: p = pad_p2;
      2'd2: p = pad_p3;
      default: p = pad_p4;
    endcase
    if (joy_out[1]) begin
      m_port = '0;
      m_latch = '0;
    end else begin
      m_latch = pad_nibble(m_port, joy_out[0], p);
      if (joy_out[0] && !m_last_sel && multitap_enable) begin
        m_port = m_port + 3'd1;
      end
    end
    m_last_sel = joy_out[0];
  endtask

  task automatic joy_step(input logic [1:0] lines, input logic mt, input logic [31:0] pads);
    pad_p1 = pce_io_pkg::pad_buttons_t'(pads[7:0]);
    pad_p2 = pce_io_pkg::pad_buttons_t'(pads[15:8]);
    pad_p3 = pce_io_pkg::pad_buttons_t'(pads[23:16]);
    pad_p4 = pce_io_pkg::pad_buttons_t'(pads[31:24]);
    joy_out = lines;
    multitap_enable = mt;
    repeat (2) begin
      model_joy_cycle();
      @(negedge clk_sys_42_95);
    end
    check_nibble(joy_in, m_latch, "joy_in");
  endtask

  // pattern from the whole word address
  task automatic fill_backup_ram();
    for (int w = 0; w < pce_io_pkg::bram_words; w++) begin
      m_mem[w] = pce_io_pkg::save_word_t'((w * 40503 + 12345) ^ (w << 6));
      sd_lba = {15'd0, w[9:8]};
      sd_buff_addr = w[7:0];
      sd_buff_dout = m_mem[w];
      sd_wr = 1'b1;
      @(negedge clk_sys_42_95);
    end
    sd_wr = 1'b0;
  endtask

  // save port reads the same word and must see the old value
  task automatic core_write(input pce_io_pkg::bram_addr_t a, input pce_io_pkg::bram_byte_t d);
    pce_io_pkg::save_word_t old;
    old = m_mem[a[10:1]];
    bram_addr = a;
    bram_data = d;
    bram_wr = 1'b1;
    sd_lba = {15'd0, a[10:9]};
    sd_buff_addr = a[8:1];
    @(negedge clk_sys_42_95);
    bram_wr = 1'b0;
    check_save_word(sd_buff_din, old, "save read during core write");
    if (a[0]) begin
      m_mem[a[10:1]][15:8] = d;
    end else begin
      m_mem[a[10:1]][7:0] = d;
    end
  endtask

  // core port reads one byte of the word being written
  task automatic save_write(input pce_io_pkg::save_lba_t lba, input pce_io_pkg::save_offset_t off,
                            input pce_io_pkg::save_word_t d, input logic hi);
    pce_io_pkg::save_word_t old;
    old = m_mem[{lba[1:0], off}];
    sd_lba = lba;
    sd_buff_addr = off;
    sd_buff_dout = d;
    sd_wr = 1'b1;
    bram_addr = {lba[1:0], off, hi};
    @(negedge clk_sys_42_95);
    sd_wr = 1'b0;
    check_byte(bram_q, hi ? old[15:8] : old[7:0], "core read during save write");
    if (lba[15:2] == '0) begin
      m_mem[{lba[1:0], off}] = d;
    end
  endtask

  task automatic core_read_check(input pce_io_pkg::bram_addr_t a);
    bram_addr = a;
    @(negedge clk_sys_42_95);
    check_byte(bram_q, a[0] ? m_mem[a[10:1]][15:8] : m_mem[a[10:1]][7:0], "bram_q");
  endtask

  // outside the internal region the save side reads zero
  task automatic save_read_check(input pce_io_pkg::save_lba_t lba,
                                 input pce_io_pkg::save_offset_t off);
    sd_lba = lba;
    sd_buff_addr = off;
    @(negedge clk_sys_42_95);
    check_save_word(sd_buff_din, (lba[15:2] == '0) ? m_mem[{lba[1:0], off}] : '0,
                    "sd_buff_din");
  endtask

  initial begin
    #(n_txn * cycles_per_txn * 2 * clk_period);
    $display("timeout: the tests did not finish within %0d clock cycles",
             n_txn * cycles_per_txn * 2);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    int n_words;
    pce_io_pkg::save_lba_t valid_lba;
    logic [13:0] mid;
    seed = 9;
    clk_sys_42_95 = 1'b0;
    reset = 1'b1;
    cart_download = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_dout = '0;
    byte_swap = 1'b0;
    core_rd_addr = '0;
    joy_out = 2'b00;
    multitap_enable = 1'b0;
    pad_p1 = '0;
    pad_p2 = '0;
    pad_p3 = '0;
    pad_p4 = '0;
    bram_addr = '0;
    bram_data = '0;
    bram_wr = 1'b0;
    sd_lba = '0;
    sd_buff_addr = '0;
    sd_buff_dout = '0;
    sd_wr = 1'b0;
    m_addr = '0;
    m_req = 1'b0;
    m_pop = 2'b11;
    m_port = '0;
    m_latch = '0;
    m_last_sel = 1'b0;
    // reset over two rising edges
    repeat (2) @(negedge clk_sys_42_95);
    reset = 1'b0;
    check_rom_addr(rom_wr_addr, '0, "rom_wr_addr after reset");
    check_bit(rom_wr_req, 1'b0, "rom_wr_req after reset");
    check_nibble(joy_in, '0, "joy_in after reset");
    check_bit(rom_populous, 1'b1, "rom_populous after reset");

    for (int d = 0; d < n_short_dl; d++) begin
      start_download();
      for (int i = 0; i < short_words; i++) begin
        r = rand32();
        write_rom_word(r[15:0], r[16]);
      end
    end

    // k picks which areas hold the signature and where bit 9 ends
    for (int k = 0; k < n_sig_dl; k++) begin
      r = rand32();
      n_words = min_sig_words + (((k % 4) == 1 || (k % 4) == 2) ? 104 + int'(r[3:0])
                                                                 : int'(r[5:0]));
      sig_download(!k[1], !k[0], n_words);
      check_header_reads(16);
    end

    // first half with multitap, second half without
    for (int i = 0; i < n_joy; i++) begin
      r = rand32();
      joy_step({r[3:0] == 4'd0, r[4]}, i < n_joy / 2, rand32());
    end

    fill_backup_ram();
    for (int i = 0; i < n_bram_ops; i++) begin
      r = rand32();
      r2 = rand32();
      valid_lba = {r[2], 14'd0, r[4:3]};
      case (r[1:0])
        2'd0: core_write(r2[10:0], r2[18:11]);
        2'd1: save_write(valid_lba, r[12:5], r2[15:0], r[13]);
        2'd2: begin
          // lba past the internal region, nothing may change
          mid = (r2[29:16] == '0) ? 14'd1 : r2[29:16];
          save_write({r[2], mid, r[4:3]}, r[12:5], r2[15:0], r[13]);
          save_read_check({r[2], mid, r[4:3]}, r[12:5]);
          save_read_check(valid_lba, r[12:5]);
        end
        default: begin
          core_read_check(r2[10:0]);
          save_read_check(valid_lba, r[12:5]);
        end
      endcase
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- pce_io_top.sv
`timescale 1ns/100ps

module pce_io_top (
  input  logic                       clk_sys_42_95,
  input  logic                       reset,
  // rom download
  input  logic                       cart_download,
  input  logic                       ioctl_wr,
  input  pce_io_pkg::rom_word_t      ioctl_dout,
  input  logic                       byte_swap,
  input  pce_io_pkg::core_rom_addr_t core_rd_addr,
  output pce_io_pkg::rom_addr_t      rom_wr_addr,
  output pce_io_pkg::rom_word_t      rom_wr_data,
  output logic                       rom_wr_req,
  output logic                       rom_populous,
  output pce_io_pkg::rom_addr_t      sdram_rd_addr,
  // joypad port
  input  logic [1:0]                 joy_out,
  input  logic                       multitap_enable,
  input  pce_io_pkg::pad_buttons_t   pad_p1,
  input  pce_io_pkg::pad_buttons_t   pad_p2,
  input  pce_io_pkg::pad_buttons_t   pad_p3,
  input  pce_io_pkg::pad_buttons_t   pad_p4,
  output pce_io_pkg::pad_nibble_t    joy_in,
  // backup ram, core side
  input  pce_io_pkg::bram_addr_t     bram_addr,
  input  pce_io_pkg::bram_byte_t     bram_data,
  input  logic                       bram_wr,
  output pce_io_pkg::bram_byte_t     bram_q,
  // backup ram, save buffer side
  input  pce_io_pkg::save_lba_t      sd_lba,
  input  pce_io_pkg::save_offset_t   sd_buff_addr,
  input  pce_io_pkg::save_word_t     sd_buff_dout,
  input  logic                       sd_wr,
  output pce_io_pkg::save_word_t     sd_buff_din
);

  cart_loader u_cart_loader (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .byte_swap     (byte_swap),
    .core_rd_addr  (core_rd_addr),
    .rom_wr_addr   (rom_wr_addr),
    .rom_wr_data   (rom_wr_data),
    .rom_wr_req    (rom_wr_req),
    .rom_populous  (rom_populous),
    .sdram_rd_addr (sdram_rd_addr)
  );

  // four pads behind an optional multitap
  joypad_mux u_joypad_mux (
    .clk_sys_42_95   (clk_sys_42_95),
    .reset           (reset),
    .joy_out         (joy_out),
    .multitap_enable (multitap_enable),
    .pad_p1          (pad_p1),
    .pad_p2          (pad_p2),
    .pad_p3          (pad_p3),
    .pad_p4          (pad_p4),
    .joy_in          (joy_in)
  );

  // memory only, keeps its contents across reset
  backup_ram u_backup_ram (
    .clk_sys_42_95 (clk_sys_42_95),
    .bram_addr     (bram_addr),
    .bram_data     (bram_data),
    .bram_wr       (bram_wr),
    .bram_q        (bram_q),
    .sd_lba        (sd_lba),
    .sd_buff_addr  (sd_buff_addr),
    .sd_buff_dout  (sd_buff_dout),
    .sd_wr         (sd_wr),
    .sd_buff_din   (sd_buff_din)
  );

endmodule

//--- backup_ram.sv
`timescale 1ns/100ps

module backup_ram (
  input  logic                     clk_sys_42_95,
  input  pce_io_pkg::bram_addr_t   bram_addr,
  input  pce_io_pkg::bram_byte_t   bram_data,
  input  logic                     bram_wr,
  output pce_io_pkg::bram_byte_t   bram_q,
  input  pce_io_pkg::save_lba_t    sd_lba,
  input  pce_io_pkg::save_offset_t sd_buff_addr,
  input  pce_io_pkg::save_word_t   sd_buff_dout,
  input  logic                     sd_wr,
  output pce_io_pkg::save_word_t   sd_buff_din
);

  // word storage split into low and high byte lanes
  pce_io_pkg::bram_byte_t mem_lo [pce_io_pkg::bram_words];
  pce_io_pkg::bram_byte_t mem_hi [pce_io_pkg::bram_words];

  logic [$clog2(pce_io_pkg::bram_words)-1:0] core_word;
  logic core_hi;
  logic [$clog2(pce_io_pkg::bram_words)-1:0] save_word;
  logic save_valid;
  logic save_we;

  // even byte address is the low half of the word
  assign core_word = bram_addr[10:1];
  assign core_hi = bram_addr[0];

  // first four sectors of the save file map onto the internal ram
  assign save_word = {sd_lba[1:0], sd_buff_addr};
  assign save_valid = (sd_lba[15:2] == '0);
  assign save_we = sd_wr & save_valid;

  always_ff @(posedge clk_sys_42_95) begin
    if (bram_wr && !core_hi) begin
      mem_lo[core_word] <= bram_data;
    end
    if (save_we) begin
      mem_lo[save_word] <= sd_buff_dout[7:0];
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (bram_wr && core_hi) begin
      mem_hi[core_word] <= bram_data;
    end
    if (save_we) begin
      mem_hi[save_word] <= sd_buff_dout[15:8];
    end
  end

  // reads see the contents from before this cycle's writes
  always_ff @(posedge clk_sys_42_95) begin
    bram_q <= core_hi ? mem_hi[core_word] : mem_lo[core_word];
    // nothing lives past the internal region
    sd_buff_din <= save_valid ? {mem_hi[save_word], mem_lo[save_word]} : '0;
  end

endmodule

//--- joypad_mux.sv
`timescale 1ns/100ps

module joypad_mux (
  input  logic                     clk_sys_42_95,
  input  logic                     reset,
  input  logic [1:0]               joy_out,
  input  logic                     multitap_enable,
  input  pce_io_pkg::pad_buttons_t pad_p1,
  input  pce_io_pkg::pad_buttons_t pad_p2,
  input  pce_io_pkg::pad_buttons_t pad_p3,
  input  pce_io_pkg::pad_buttons_t pad_p4,
  output pce_io_pkg::pad_nibble_t  joy_in
);

  // core side lines
  logic clear_line;
  logic sel_line;

  // select level seen last cycle
  logic last_sel;
  logic sel_rise;

  // current multitap port and the latched nibble
  pce_io_pkg::tap_port_t port;
  pce_io_pkg::pad_nibble_t latch;

  // pad picked by the low port bits
  pce_io_pkg::pad_buttons_t pad_sel;
  pce_io_pkg::pad_nibble_t nibble;

  assign clear_line = joy_out[1];
  assign sel_line = joy_out[0];
  assign sel_rise = sel_line & ~last_sel;

  always_comb begin
    case (port[1:0])
      2'd0: pad_sel = pad_p1;
      2'd1: pad_sel = pad_p2;
      2'd2: pad_sel = pad_p3;
      default: pad_sel = pad_p4;
    endcase
  end

  // lines are active low toward the core
  always_comb begin
    if (port[2]) begin
      // ports 4 to 7 have nothing plugged in
      nibble = 4'hf;
    end else if (sel_line) begin
      // direction half
      nibble = ~{pad_sel.up, pad_sel.right, pad_sel.left, pad_sel.down};
    end else begin
      // button half
      nibble = ~{pad_sel.start, pad_sel.select, pad_sel.b, pad_sel.a};
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      last_sel <= 1'b0;
      port <= '0;
      latch <= '0;
    end else begin
      last_sel <= sel_line;
      // reload every cycle with the pad as it is now
      latch <= nibble;
      if (clear_line) begin
        // clear rewinds the scan and blanks the port
        port <= '0;
        latch <= '0;
      end else if (sel_rise && multitap_enable) begin
        // wraps back to port 0 after port 7
        port <= port + pce_io_pkg::tap_port_t'(1);
      end
    end
  end

  // one cycle behind the pad and line inputs
  assign joy_in = latch;

endmodule

//--- cart_loader.sv
`timescale 1ns/100ps

module cart_loader (
  input  logic                       clk_sys_42_95,
  input  logic                       reset,
  input  logic                       cart_download,
  input  logic                       ioctl_wr,
  input  pce_io_pkg::rom_word_t      ioctl_dout,
  input  logic                       byte_swap,
  input  pce_io_pkg::core_rom_addr_t core_rd_addr,
  output pce_io_pkg::rom_addr_t      rom_wr_addr,
  output pce_io_pkg::rom_word_t      rom_wr_data,
  output logic                       rom_wr_req,
  output logic                       rom_populous,
  output pce_io_pkg::rom_addr_t      sdram_rd_addr
);

  // previous input levels for edge detection
  logic prev_download;
  logic prev_wr;
  logic download_rise;
  logic wr_rise;
  logic wr_fall;

  // reversed download word
  pce_io_pkg::rom_word_t swapped;

  // one flag per 8k half, picked by address bit 13
  logic [1:0] populous;

  logic in_sig_block;
  logic sig_slot;
  pce_io_pkg::rom_word_t sig_expect;
  logic sig_mismatch;

  // header skip for core reads
  pce_io_pkg::core_rom_addr_t rd_offset;
  pce_io_pkg::core_rom_addr_t rd_translated;

  assign download_rise = cart_download & ~prev_download;
  assign wr_rise = ioctl_wr & ~prev_wr;
  assign wr_fall = ~ioctl_wr & prev_wr;

  // swap mode reverses the whole word
  // so bytes exchange and each byte flips its bit order
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      swapped[i] = ioctl_dout[15-i];
    end
  end

  assign rom_wr_data = byte_swap ? swapped : ioctl_dout;

  // signature lives in two 16-byte areas
  assign in_sig_block = (rom_wr_addr[23:4] == pce_io_pkg::populous_block_a) ||
                        (rom_wr_addr[23:4] == pce_io_pkg::populous_block_b);

  // only four word slots inside the area are checked
  always_comb begin
    sig_slot = 1'b1;
    sig_expect = '0;
    case (rom_wr_addr[3:0])
      4'd6: sig_expect = pce_io_pkg::sig_word_6;
      4'd8: sig_expect = pce_io_pkg::sig_word_8;
      4'd10: sig_expect = pce_io_pkg::sig_word_10;
      4'd12: sig_expect = pce_io_pkg::sig_word_12;
      default: sig_slot = 1'b0;
    endcase
  end

  // compare against the word as it goes to memory
  assign sig_mismatch = in_sig_block && sig_slot && (rom_wr_data != sig_expect);

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      prev_download <= 1'b0;
      prev_wr <= 1'b0;
      rom_wr_addr <= '0;
      rom_wr_req <= 1'b0;
      populous <= 2'b11;
    end else begin
      prev_download <= cart_download;
      prev_wr <= ioctl_wr;
      if (download_rise) begin
        // new cart, start over and assume populous until disproved
        rom_wr_addr <= '0;
        populous <= 2'b11;
      end else if (wr_rise) begin
        // toggle tells the memory side a word is waiting
        rom_wr_req <= ~rom_wr_req;
        if (sig_mismatch) begin
          populous[rom_wr_addr[13]] <= 1'b0;
        end
      end else if (wr_fall) begin
        // word done, step to next word
        rom_wr_addr <= rom_wr_addr + pce_io_pkg::rom_addr_t'(2);
      end
    end
  end

  // bit 9 of the length tells whether a header precedes the image
  assign rom_populous = populous[rom_wr_addr[9]];

  assign rd_offset = rom_wr_addr[9] ?
                     pce_io_pkg::core_rom_addr_t'(pce_io_pkg::header_offset) : '0;

  // sum wraps inside the core address space
  assign rd_translated = core_rd_addr + rd_offset;
  assign sdram_rd_addr = pce_io_pkg::rom_addr_t'(rd_translated);

endmodule

//--- pce_io_pkg.sv
package pce_io_pkg;

  // rom download address, byte granular
  localparam int rom_addr_w = 24;
  // address the core uses for hucard reads
  localparam int core_rom_addr_w = 22;
  // copier header some dumps carry in front of the image
  localparam int header_offset = 512;

  // backup memory depth in 16-bit words
  localparam int bram_words = 1024;

  typedef logic [rom_addr_w-1:0] rom_addr_t;
  typedef logic [core_rom_addr_w-1:0] core_rom_addr_t;
  typedef logic [15:0] rom_word_t;

  // one pad, active high, start in bit 7
  typedef struct packed {
    logic start;
    logic select;
    logic b;
    logic a;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_buttons_t;

  // nibble seen by the core on its joypad port
  typedef logic [3:0] pad_nibble_t;
  // multitap port number
  typedef logic [2:0] tap_port_t;

  // backup ram, core side is bytes
  typedef logic [10:0] bram_addr_t;
  typedef logic [7:0] bram_byte_t;

  // save buffer side is words
  typedef logic [15:0] save_word_t;
  typedef logic [16:0] save_lba_t;
  typedef logic [7:0] save_offset_t;

  // populous signature areas, address bits 23..4
  localparam logic [19:0] populous_block_a = 20'h212;
  localparam logic [19:0] populous_block_b = 20'h1f2;

  // expected words at low nibble offsets 6, 8, 10, 12
  localparam rom_word_t sig_word_6 = 16'h4f50;
  localparam rom_word_t sig_word_8 = 16'h5550;
  localparam rom_word_t sig_word_10 = 16'h4f4c;
  localparam rom_word_t sig_word_12 = 16'h5355;

endpackage
